// File: source/fu_pkg.sv
`default_nettype none

package fu_pkg;

	localparam int xlen = 32;	// data path width
	localparam int tag_bits = 6;	// destination tag width

	// operand a source
	typedef enum logic [1:0] {
		opa_is_rs1  = 2'h0,
		opa_is_npc  = 2'h1,
		opa_is_pc   = 2'h2,
		opa_is_zero = 2'h3
	} opa_sel_t;

	// operand b source, codes 6 and 7 give zero
	typedef enum logic [2:0] {
		opb_is_rs2   = 3'h0,
		opb_is_i_imm = 3'h1,
		opb_is_s_imm = 3'h2,
		opb_is_b_imm = 3'h3,
		opb_is_u_imm = 3'h4,
		opb_is_j_imm = 3'h5
	} opb_sel_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_slt, alu_sltu, alu_or, alu_xor,
		alu_srl, alu_sll, alu_sra,
		alu_mul, alu_mulh, alu_mulhsu, alu_mulhu	// codes 14, 15 unused
	} alu_func_t;

	localparam logic stage_empty = 1'b0;		// fill flag after reset or squash
	localparam logic [xlen-1:0] zero_word = '0;	// value of unused selects and funcs

endpackage

`default_nettype wire

// File: source/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_view_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_view_t;

	typedef struct packed {
		logic [6:0] imm_hi;	// imm[11:5]
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;	// imm[4:0]
		logic [6:0] opcode;
	} s_view_t;

	// branch offset is scattered, bit 0 is always zero
	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_view_t;

	typedef struct packed {
		logic [19:0] imm;	// upper 20 bits
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_view_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_view_t;

	typedef union packed {
		r_view_t r;
		i_view_t i;
		s_view_t s;
		b_view_t b;
		u_view_t u;
		j_view_t j;
	} inst_word_t;

	function automatic logic [31:0] imm_i(inst_word_t w);
		return {{20{w.i.imm[11]}}, w.i.imm};
	endfunction

	function automatic logic [31:0] imm_s(inst_word_t w);
		return {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
	endfunction

	function automatic logic [31:0] imm_b(inst_word_t w);
		return {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
	endfunction

	function automatic logic [31:0] imm_u(inst_word_t w);
		return {w.u.imm, 12'h000};
	endfunction

	function automatic logic [31:0] imm_j(inst_word_t w);
		return {{11{w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0};
	endfunction

endpackage

`default_nettype wire

// File: source/fu_stage_if.sv
`default_nettype none

// issue slot to operand stage
interface issue_link_if import fu_pkg::*, rv32_pkg::*;;
	logic                valid;
	logic [xlen-1:0]     pc;
	logic [xlen-1:0]     npc;
	inst_word_t          inst;
	logic [xlen-1:0]     rs1_value;
	logic [xlen-1:0]     rs2_value;
	opa_sel_t            opa_sel;
	opb_sel_t            opb_sel;
	alu_func_t           alu_func;
	logic                cond_branch;
	logic                uncond_branch;
	logic [tag_bits-1:0] tag;
	logic                accept;	// consumer empty or draining

	modport producer (
		output valid, pc, npc, inst, rs1_value, rs2_value, opa_sel, opb_sel, alu_func,
		output cond_branch, uncond_branch, tag,
		input accept
	);

	modport consumer (
		input valid, pc, npc, inst, rs1_value, rs2_value, opa_sel, opb_sel, alu_func,
		input cond_branch, uncond_branch, tag,
		output accept
	);
endinterface

// operand stage to execute stage
interface exec_link_if import fu_pkg::*;;
	logic                valid;
	logic [xlen-1:0]     opa;
	logic [xlen-1:0]     opb;
	logic [xlen-1:0]     rs1_value;	// raw values for the branch compare
	logic [xlen-1:0]     rs2_value;
	alu_func_t           alu_func;
	logic [2:0]          branch_funct3;
	logic                cond_branch;
	logic                uncond_branch;
	logic [tag_bits-1:0] tag;
	logic                accept;

	modport producer (
		output valid, opa, opb, rs1_value, rs2_value, alu_func, branch_funct3,
		output cond_branch, uncond_branch, tag,
		input accept
	);

	modport consumer (
		input valid, opa, opb, rs1_value, rs2_value, alu_func, branch_funct3,
		input cond_branch, uncond_branch, tag,
		output accept
	);
endinterface

`default_nettype wire

// File: source/issue_slot.sv
`default_nettype none

module issue_slot import fu_pkg::*, rv32_pkg::*; (
	input  logic                clock,
	input  logic                rst,
	input  logic                squash,
	input  logic                issue_valid,
	input  logic [xlen-1:0]     issue_pc,
	input  inst_word_t          issue_inst,
	input  logic [xlen-1:0]     issue_rs1,
	input  logic [xlen-1:0]     issue_rs2,
	input  opa_sel_t            issue_opa_sel,
	input  opb_sel_t            issue_opb_sel,
	input  alu_func_t           issue_alu_func,
	input  logic                issue_cond_branch,
	input  logic                issue_uncond_branch,
	input  logic [tag_bits-1:0] issue_tag,
	output logic                busy,
	issue_link_if.producer      link
);
	logic full;
	logic take;

	assign busy = full && !link.accept;	// full and not moving on this edge
	assign take = issue_valid && !busy;
	assign link.valid = full;

	always_ff @(posedge clock) begin
		if (rst || squash) begin
			full <= stage_empty;
		end else if (take) begin
			full <= 1'b1;
		end else if (link.accept) begin
			full <= stage_empty;	// drained, nothing new
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			link.pc            <= issue_pc;
			link.npc           <= issue_pc + xlen'(4);	// next sequential pc
			link.inst          <= issue_inst;
			link.rs1_value     <= issue_rs1;
			link.rs2_value     <= issue_rs2;
			link.opa_sel       <= issue_opa_sel;
			link.opb_sel       <= issue_opb_sel;
			link.alu_func      <= issue_alu_func;
			link.cond_branch   <= issue_cond_branch;
			link.uncond_branch <= issue_uncond_branch;
			link.tag           <= issue_tag;
		end
	end
endmodule

`default_nettype wire

// File: source/operand_select.sv
`default_nettype none

module operand_select import fu_pkg::*, rv32_pkg::*; (
	input  logic           clock,
	input  logic           rst,
	input  logic           squash,
	issue_link_if.consumer up,
	exec_link_if.producer  down
);
	logic            full;
	logic            take;
	logic [xlen-1:0] opa_mux;
	logic [xlen-1:0] opb_mux;

	assign up.accept = !full || down.accept;
	assign take = up.valid && up.accept;
	assign down.valid = full;

	always_comb begin
		case (up.opa_sel)
			opa_is_rs1:  opa_mux = up.rs1_value;
			opa_is_npc:  opa_mux = up.npc;	// link address for jal/jalr
			opa_is_pc:   opa_mux = up.pc;
			default:     opa_mux = zero_word;
		endcase
	end

	// immediates decoded from the format views of the word
	always_comb begin
		case (up.opb_sel)
			opb_is_rs2:   opb_mux = up.rs2_value;
			opb_is_i_imm: opb_mux = imm_i(up.inst);
			opb_is_s_imm: opb_mux = imm_s(up.inst);
			opb_is_b_imm: opb_mux = imm_b(up.inst);
			opb_is_u_imm: opb_mux = imm_u(up.inst);
			opb_is_j_imm: opb_mux = imm_j(up.inst);
			default:      opb_mux = zero_word;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst || squash) begin
			full <= stage_empty;
		end else if (take) begin
			full <= 1'b1;
		end else if (down.accept) begin
			full <= stage_empty;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			down.opa           <= opa_mux;
			down.opb           <= opb_mux;
			down.rs1_value     <= up.rs1_value;
			down.rs2_value     <= up.rs2_value;
			down.alu_func      <= up.alu_func;
			down.branch_funct3 <= up.inst.b.funct3;
			down.cond_branch   <= up.cond_branch;
			down.uncond_branch <= up.uncond_branch;
			down.tag           <= up.tag;
		end
	end
endmodule

`default_nettype wire

// File: source/alu_core.sv
`default_nettype none

module alu_core import fu_pkg::*; (
	input  logic [xlen-1:0] opa,
	input  logic [xlen-1:0] opb,
	input  alu_func_t       func,
	output logic [xlen-1:0] result
);
	logic signed [xlen-1:0]   sopa;
	logic signed [xlen-1:0]   sopb;
	logic signed [2*xlen-1:0] prod_ss;
	logic signed [2*xlen-1:0] prod_su;
	logic        [2*xlen-1:0] prod_uu;
	logic        [4:0]        shamt;

	assign sopa = opa;
	assign sopb = opb;
	assign shamt = opb[4:0];

	// operands widened to 64 bits before each multiply
	assign prod_ss = $signed({{xlen{opa[xlen-1]}}, opa}) * $signed({{xlen{opb[xlen-1]}}, opb});
	assign prod_uu = {{xlen{1'b0}}, opa} * {{xlen{1'b0}}, opb};
	// rs1 signed times rs2 unsigned
	assign prod_su = $signed({{xlen{opa[xlen-1]}}, opa}) * $signed({{xlen{1'b0}}, opb});

	always_comb begin
		case (func)
			alu_add:    result = opa + opb;
			alu_sub:    result = opa - opb;
			alu_and:    result = opa & opb;
			alu_slt:    result = {{(xlen-1){1'b0}}, sopa < sopb};
			alu_sltu:   result = {{(xlen-1){1'b0}}, opa < opb};
			alu_or:     result = opa | opb;
			alu_xor:    result = opa ^ opb;
			alu_srl:    result = opa >> shamt;
			alu_sll:    result = opa << shamt;
			alu_sra:    result = sopa >>> shamt;	// sign fill
			alu_mul:    result = prod_ss[xlen-1:0];	// low half same for all signs
			alu_mulh:   result = prod_ss[2*xlen-1:xlen];
			alu_mulhsu: result = prod_su[2*xlen-1:xlen];
			alu_mulhu:  result = prod_uu[2*xlen-1:xlen];
			default:    result = zero_word;
		endcase
	end
endmodule

`default_nettype wire

// File: source/execute_stage.sv
`default_nettype none

module execute_stage import fu_pkg::*; (
	input  logic                clock,
	input  logic                rst,
	input  logic                squash,
	input  logic                selected,
	exec_link_if.consumer       up,
	output logic                done_valid,
	output logic                done_take_branch,
	output logic [xlen-1:0]     done_result,
	output logic [tag_bits-1:0] done_tag
);
	logic            full;
	logic            take;
	logic            cond;
	logic            take_branch;
	logic [xlen-1:0] alu_result;

	alu_core alu_core_i (
		.opa    (up.opa),
		.opb    (up.opb),
		.func   (up.alu_func),
		.result (alu_result)
	);

	// branch compare on the raw register values
	always_comb begin
		case (up.branch_funct3)
			3'b000:  cond = up.rs1_value == up.rs2_value;	// beq
			3'b001:  cond = up.rs1_value != up.rs2_value;	// bne
			3'b100:  cond = $signed(up.rs1_value) < $signed(up.rs2_value);	// blt
			3'b101:  cond = $signed(up.rs1_value) >= $signed(up.rs2_value);	// bge
			3'b110:  cond = up.rs1_value < up.rs2_value;	// bltu
			3'b111:  cond = up.rs1_value >= up.rs2_value;	// bgeu
			default: cond = 1'b0;
		endcase
	end

	assign take_branch = up.uncond_branch || (up.cond_branch && cond);

	// result is held until the completion bus picks it
	assign up.accept = !full || selected;
	assign take = up.valid && up.accept;
	assign done_valid = full;

	always_ff @(posedge clock) begin
		if (rst || squash) begin
			full <= stage_empty;
		end else if (take) begin
			full <= 1'b1;
		end else if (selected) begin
			full <= stage_empty;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			done_result      <= alu_result;
			done_take_branch <= take_branch;
			done_tag         <= up.tag;
		end
	end
endmodule

`default_nettype wire

// File: source/alu_unit.sv
`default_nettype none

module alu_unit import fu_pkg::*, rv32_pkg::*; (
	input  logic                clock,
	input  logic                rst,
	input  logic                squash,
	input  logic                selected,	// completion bus grant, one pulse per result
	input  logic                issue_valid,
	input  logic [xlen-1:0]     issue_pc,
	input  inst_word_t          issue_inst,
	input  logic [xlen-1:0]     issue_rs1,
	input  logic [xlen-1:0]     issue_rs2,
	input  opa_sel_t            issue_opa_sel,
	input  opb_sel_t            issue_opb_sel,
	input  alu_func_t           issue_alu_func,
	input  logic                issue_cond_branch,
	input  logic                issue_uncond_branch,
	input  logic [tag_bits-1:0] issue_tag,
	output logic                busy,
	output logic                done_valid,
	output logic [xlen-1:0]     done_result,
	output logic                done_take_branch,
	output logic [tag_bits-1:0] done_tag
);
	issue_link_if issue_link ();
	exec_link_if  exec_link ();

	issue_slot issue_slot_i (
		.clock               (clock),
		.rst                 (rst),
		.squash              (squash),
		.issue_valid         (issue_valid),
		.issue_pc            (issue_pc),
		.issue_inst          (issue_inst),
		.issue_rs1           (issue_rs1),
		.issue_rs2           (issue_rs2),
		.issue_opa_sel       (issue_opa_sel),
		.issue_opb_sel       (issue_opb_sel),
		.issue_alu_func      (issue_alu_func),
		.issue_cond_branch   (issue_cond_branch),
		.issue_uncond_branch (issue_uncond_branch),
		.issue_tag           (issue_tag),
		.busy                (busy),
		.link                (issue_link.producer)
	);

	operand_select operand_select_i (
		.clock  (clock),
		.rst    (rst),
		.squash (squash),
		.up     (issue_link.consumer),
		.down   (exec_link.producer)
	);

	execute_stage execute_stage_i (
		.clock            (clock),
		.rst              (rst),
		.squash           (squash),
		.selected         (selected),
		.up               (exec_link.consumer),
		.done_valid       (done_valid),
		.done_take_branch (done_take_branch),
		.done_result      (done_result),
		.done_tag         (done_tag)
	);
endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic clock
);
	timeunit 1ns;
	timeprecision 100ps;

	initial clock = 1'b0;

	always #4 clock = ~clock;	// 8 ns period
endmodule

`default_nettype wire

// File: verif/alu_unit_tb.sv
`default_nettype none

module alu_unit_tb import fu_pkg::*, rv32_pkg::*; ;
	timeunit 1ns;
	timeprecision 100ps;

	logic clock, rst, squash, selected, issue_valid;
	logic [xlen-1:0] issue_pc, issue_rs1, issue_rs2;
	inst_word_t issue_inst;
	opa_sel_t issue_opa_sel;
	opb_sel_t issue_opb_sel;
	alu_func_t issue_alu_func;
	logic issue_cond_branch, issue_uncond_branch;
	logic [tag_bits-1:0] issue_tag, done_tag;
	logic busy, done_valid, done_take_branch;
	logic [xlen-1:0] done_result;

	tb_clock tb_clock_i (.clock(clock));

	alu_unit alu_unit_i (.*);

	task automatic end_on_failure();
		$display("TEST FAIL");
		$fatal(1, "run stopped after a failure");
	endtask

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s got 0x%h expected 0x%h", $time, name, got, exp);
			end_on_failure();
		end
	endtask

	// expected alu result, mulh variants from the unsigned product with sign corrections
	function automatic logic [31:0] ref_alu(alu_func_t f, logic [31:0] a, logic [31:0] b);
		logic [63:0] uu;
		uu = {32'h0, a} * {32'h0, b};
		case (f)
			alu_add:    return a + b;
			alu_sub:    return a - b;
			alu_and:    return a & b;
			alu_or:     return a | b;
			alu_xor:    return a ^ b;
			alu_slt:    return {31'h0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
			alu_sltu:   return {31'h0, a < b};
			alu_srl:    return a >> b[4:0];
			alu_sll:    return a << b[4:0];
			alu_sra:    return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
			alu_mul:    return uu[31:0];
			alu_mulhu:  return uu[63:32];
			alu_mulhsu: return uu[63:32] - (a[31] ? b : 32'h0);
			alu_mulh:   return uu[63:32] - (a[31] ? b : 32'h0) - (b[31] ? a : 32'h0);
			default:    return 32'h0;
		endcase
	endfunction

	function automatic logic ref_cond(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		logic lt_s;
		lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return lt_s;
			3'b101:  return !lt_s;
			3'b110:  return a < b;
			3'b111:  return !(a < b);
			default: return 1'b0;
		endcase
	endfunction

	task automatic drive_op(opa_sel_t sa, opb_sel_t sb, alu_func_t f, logic [31:0] inst,
			logic [31:0] pc, logic [31:0] rs1, logic [31:0] rs2, logic cond, logic uncond,
			logic [tag_bits-1:0] tag);
		issue_opa_sel = sa;
		issue_opb_sel = sb;
		issue_alu_func = f;
		issue_inst = inst;
		issue_pc = pc;
		issue_rs1 = rs1;
		issue_rs2 = rs2;
		issue_cond_branch = cond;
		issue_uncond_branch = uncond;
		issue_tag = tag;
		issue_valid = 1'b1;
	endtask

	task automatic issue_op(opa_sel_t sa, opb_sel_t sb, alu_func_t f, logic [31:0] inst,
			logic [31:0] pc, logic [31:0] rs1, logic [31:0] rs2, logic cond, logic uncond,
			logic [tag_bits-1:0] tag);
		int tries;
		tries = 0;
		drive_op(sa, sb, f, inst, pc, rs1, rs2, cond, uncond, tag);
		while (busy) begin
			if (tries == 20) begin
				$display("timed out waiting for busy to drop before an issue");
				end_on_failure();
			end
			@(posedge clock);
			#1;
			tries++;
		end
		@(posedge clock);	// accepted here
		#1;
		issue_valid = 1'b0;
	endtask

	task automatic retire(logic [31:0] exp_res, logic exp_br, logic [tag_bits-1:0] exp_tag,
			bit check_latency);
		int cycles;
		cycles = 0;
		while (!done_valid) begin
			if (cycles == 20) begin
				$display("timed out waiting for done_valid");
				end_on_failure();
			end
			@(posedge clock);
			#1;
			cycles++;
		end
		if (check_latency)
			check("latency", 32'(cycles), 32'd2);
		check("done_result", done_result, exp_res);
		check("done_take_branch", 32'(done_take_branch), 32'(exp_br));
		check("done_tag", 32'(done_tag), 32'(exp_tag));
		selected = 1'b1;
		@(posedge clock);
		#1;
		selected = 1'b0;
		issue_valid = 1'b0;	// a waiting issue went in at that edge
	endtask

	task automatic reset_test();
		repeat (5) begin
			check("busy", 32'(busy), 32'd0);
			check("done_valid", 32'(done_valid), 32'd0);
			@(posedge clock);
			#1;
		end
	endtask

	task automatic reg_reg_test();
		logic [31:0] a_set[8];
		logic [31:0] b_set[8];
		logic [tag_bits-1:0] tag;
		a_set = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000, 32'hffff_ffff,
			32'h0, 32'h0, 32'h0};
		b_set = '{32'h0, 32'hffff_ffff, 32'hffff_ffff, 32'd31, 32'd31, 32'h0, 32'h0, 32'h0};
		for (int f = 0; f < 14; f++) begin
			for (int k = 5; k < 8; k++) begin	// fresh random pairs per func
				a_set[k] = $urandom;
				b_set[k] = $urandom;
			end
			for (int k = 0; k < 8; k++) begin
				tag = tag_bits'($urandom);
				issue_op(opa_is_rs1, opb_is_rs2, alu_func_t'(4'(f)), 32'h0, 32'h0,
					a_set[k], b_set[k], 1'b0, 1'b0, tag);
				retire(ref_alu(alu_func_t'(4'(f)), a_set[k], b_set[k]), 1'b0, tag, 1);
			end
		end
	endtask

	task automatic immediate_test();
		logic [31:0] words[5];
		logic [31:0] hand_imm[5];
		logic [31:0] imm, pc;
		opb_sel_t sb;
		// addi -5, sw -4, beq -4, lui, jal +2048
		words = '{32'hffb1_0093, 32'hfe11_2e23, 32'hfe20_8ee3, 32'h1234_50b7, 32'h0010_00ef};
		hand_imm = '{32'hffff_fffb, 32'hffff_fffc, 32'hffff_fffc, 32'h1234_5000, 32'h0000_0800};
		for (int k = 0; k < 5; k++) begin
			sb = opb_sel_t'(3'(k + 1));
			case (sb)
				opb_is_i_imm: imm = imm_i(words[k]);
				opb_is_s_imm: imm = imm_s(words[k]);
				opb_is_b_imm: imm = imm_b(words[k]);
				opb_is_u_imm: imm = imm_u(words[k]);
				default:      imm = imm_j(words[k]);
			endcase
			check("immediate", imm, hand_imm[k]);
			pc = 32'h0000_1000 + 32'(k * 256);
			issue_op(opa_is_pc, sb, alu_add, words[k], pc, $urandom, $urandom, 1'b0, 1'b0, 6'd1);
			retire(pc + imm, 1'b0, 6'd1, 1);
			issue_op(opa_is_npc, sb, alu_add, words[k], pc, $urandom, $urandom, 1'b0, 1'b0, 6'd2);
			retire(pc + 32'd4 + imm, 1'b0, 6'd2, 1);
			issue_op(opa_is_zero, sb, alu_add, words[k], pc, $urandom, $urandom, 1'b0, 1'b0, 6'd3);
			retire(imm, 1'b0, 6'd3, 1);
		end
	endtask

	task automatic branch_test();
		logic [2:0] f3_set[6];
		logic [31:0] a_set[5];
		logic [31:0] b_set[5];
		inst_word_t w;
		f3_set = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		a_set = '{32'd5, 32'hffff_fff0, 32'd16, 32'd3, 32'd9};
		b_set = '{32'd5, 32'd16, 32'hffff_fff0, 32'd9, 32'd3};
		w = 32'hfe20_8ee3;
		for (int i = 0; i < 6; i++) begin
			w.b.funct3 = f3_set[i];
			for (int k = 0; k < 5; k++) begin
				issue_op(opa_is_rs1, opb_is_rs2, alu_sub, w, 32'h200, a_set[k], b_set[k],
					1'b1, 1'b0, 6'(i));
				retire(a_set[k] - b_set[k], ref_cond(f3_set[i], a_set[k], b_set[k]), 6'(i), 1);
			end
		end
		w.b.funct3 = 3'b010;	// not a branch code
		issue_op(opa_is_rs1, opb_is_rs2, alu_sub, w, 32'h200, 32'd7, 32'd7, 1'b1, 1'b0, 6'd8);
		retire(32'd0, 1'b0, 6'd8, 1);
		// jal style, link address in the result
		issue_op(opa_is_npc, opb_is_rs2, alu_add, w, 32'h300, 32'd1, 32'd0, 1'b0, 1'b1, 6'd9);
		retire(32'h304, 1'b1, 6'd9, 1);
	endtask

	task automatic backpressure_test();
		logic [31:0] vals[4];
		for (int k = 0; k < 4; k++)
			vals[k] = $urandom;
		for (int k = 0; k < 3; k++)
			issue_op(opa_is_rs1, opb_is_rs2, alu_add, 32'h0, 32'h0, vals[k], 32'h100,
				1'b0, 1'b0, 6'(20 + k));
		check("busy", 32'(busy), 32'd1);
		drive_op(opa_is_rs1, opb_is_rs2, alu_add, 32'h0, 32'h0, vals[3], 32'h100,
			1'b0, 1'b0, 6'd23);
		repeat (3) begin	// fourth op must stay out
			@(posedge clock);
			#1;
			check("busy", 32'(busy), 32'd1);
			check("done_tag", 32'(done_tag), 32'd20);
		end
		for (int k = 0; k < 4; k++)
			retire(vals[k] + 32'h100, 1'b0, 6'(20 + k), 0);
	endtask

	task automatic squash_test();
		for (int k = 0; k < 3; k++)
			issue_op(opa_is_rs1, opb_is_rs2, alu_xor, 32'h0, 32'h0, $urandom, $urandom,
				1'b0, 1'b0, 6'(40 + k));
		squash = 1'b1;
		@(posedge clock);
		#1;
		squash = 1'b0;
		check("done_valid", 32'(done_valid), 32'd0);
		check("busy", 32'(busy), 32'd0);
		@(posedge clock);
		#1;
		check("done_valid", 32'(done_valid), 32'd0);
		issue_op(opa_is_rs1, opb_is_rs2, alu_mul, 32'h0, 32'h0, 32'd1234, 32'd5678,
			1'b0, 1'b0, 6'd50);
		retire(32'd7006652, 1'b0, 6'd50, 1);
	endtask

	initial begin
		void'($urandom(32'h830c_38cd));
		rst = 1'b1;
		squash = 1'b0;
		selected = 1'b0;
		issue_valid = 1'b0;
		drive_op(opa_is_rs1, opb_is_rs2, alu_add, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 6'd0);
		issue_valid = 1'b0;
		repeat (10) @(posedge clock);
		#1;
		rst = 1'b0;
		reset_test();
		reg_reg_test();
		immediate_test();
		branch_test();
		backpressure_test();
		squash_test();
		$display("TEST PASS");
		$finish;
	end
endmodule

`default_nettype wire

// File: alu_unit.f
source/fu_pkg.sv
source/rv32_pkg.sv
source/fu_stage_if.sv
source/issue_slot.sv
source/operand_select.sv
source/alu_core.sv
source/execute_stage.sv
source/alu_unit.sv
verif/tb_clock.sv
verif/alu_unit_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -j 0 -f alu_unit.f \
		--top-module alu_unit_tb -o alu_unit_sim
	./obj_dir/alu_unit_sim | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
